//--- Bender.yml
package:
  name: lsu

sources:
  - files:
      - verilog/lsu_pkg.sv
      - verilog/ls_req_if.sv
      - verilog/mem_stage.sv
      - verilog/req_fifo.sv
      - verilog/wb_master.sv
      - verilog/lsu_top.sv
  - target: simulation
    files:
      - sim/wb_mem_model.sv
      - sim/tb_lsu.sv

//--- sim/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  localparam int WAIT_LIMIT = 200;

  logic              clock;
  logic              arst_n;
  logic              load_inst;
  logic              store_inst;
  lsu_pkg::ls_op_t   ls_op;
  logic              ls_sext;
  lsu_pkg::reg_idx_t dest_reg;
  lsu_pkg::addr_t    alu_result;
  lsu_pkg::word_t    result_2;
  lsu_pkg::word_t    result_from_mem_wb;
  lsu_pkg::fwd_t     B_fwd_from;
  lsu_pkg::word_t    result;
  logic              stall;
  logic              load_done;
  lsu_pkg::word_t    load_data;
  lsu_pkg::reg_idx_t load_dest;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  lsu_pkg::waddr_t   wb_adr;
  lsu_pkg::be_t      wb_sel;
  lsu_pkg::word_t    wb_dat_o;
  lsu_pkg::word_t    wb_dat_i;
  logic              wb_ack;

  lsu_pkg::word_t    ref_mem [256];   // Expected memory contents
  lsu_pkg::be_t      log_sel[$];      // Completed bus writes, in order
  lsu_pkg::word_t    log_dat[$];
  lsu_pkg::waddr_t   log_adr[$];
  integer            seed;
  int                checks;
  int                errors;
  int                timeouts;
  logic              stall_seen;

  lsu_top #(.FIFO_DEPTH(4)) dut0 (.*);

  wb_mem_model u_mem (
    .clock (clock), .arst_n (arst_n), .cyc (wb_cyc), .stb (wb_stb), .we (wb_we),
    .adr (wb_adr), .sel (wb_sel), .dat_w (wb_dat_o), .dat_r (wb_dat_i), .ack (wb_ack)
  );

  always #5 clock = ~clock;

  always @(negedge clock) begin
    if (wb_cyc && wb_stb && wb_ack && wb_we) begin
      log_sel.push_back(wb_sel);
      log_dat.push_back(wb_dat_o);
      log_adr.push_back(wb_adr);
    end
  end

  function automatic lsu_pkg::be_t lane_mask(lsu_pkg::ls_op_t op, lsu_pkg::byte_idx_t idx);
    case (op)
      lsu_pkg::OP_LS_BYTE:     return lsu_pkg::be_t'(1 << (3 - int'(idx)));
      lsu_pkg::OP_LS_HALFWORD: return lsu_pkg::be_t'(4'b0011 << (2 - int'(idx)));
      default:                 return 4'hf;
    endcase
  endfunction

  // Store data shifted into the addressed lanes
  function automatic lsu_pkg::word_t placed(lsu_pkg::ls_op_t op, lsu_pkg::byte_idx_t idx,
                                            lsu_pkg::word_t data);
    case (op)
      lsu_pkg::OP_LS_BYTE:     return {24'h0, data[7:0]} << (24 - 8 * int'(idx));
      lsu_pkg::OP_LS_HALFWORD: return {16'h0, data[15:0]} << (16 - 8 * int'(idx));
      default:                 return data;
    endcase
  endfunction

  function automatic void store_ref(lsu_pkg::ls_op_t op, lsu_pkg::addr_t addr,
                                    lsu_pkg::word_t data);
    lsu_pkg::be_t   mask;
    lsu_pkg::word_t lanes;
    int             w;
    mask  = lane_mask(op, addr[1:0]);
    lanes = placed(op, addr[1:0], data);
    w     = addr[9:2];
    for (int l = 0; l < 4; l++) begin
      if (mask[3-l]) ref_mem[w][31-8*l -: 8] = lanes[31-8*l -: 8];
    end
  endfunction

  function automatic lsu_pkg::word_t expect_load(lsu_pkg::word_t w, lsu_pkg::ls_op_t op,
                                                 logic sext, lsu_pkg::byte_idx_t idx);
    lsu_pkg::word_t v;
    v = w;
    if (op == lsu_pkg::OP_LS_BYTE) begin
      v = (w >> (24 - 8 * int'(idx))) & 32'hff;
      if (sext && v[7]) v = v | 32'hffff_ff00;
    end else if (op == lsu_pkg::OP_LS_HALFWORD) begin
      v = (w >> (16 - 8 * int'(idx))) & 32'hffff;
      if (sext && v[15]) v = v | 32'hffff_0000;
    end
    return v;
  endfunction

  task automatic check_word(input string what, input lsu_pkg::word_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_be(input string what, input lsu_pkg::be_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_dest(input string what, input lsu_pkg::reg_idx_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_adr(input string what, input lsu_pkg::waddr_t got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic issue_request(input logic ld, input lsu_pkg::ls_op_t op, input logic sext,
                               input lsu_pkg::reg_idx_t dest, input lsu_pkg::addr_t addr,
                               input lsu_pkg::word_t r2, rwb, input lsu_pkg::fwd_t fwd);
    int waited;
    load_inst          = ld;
    store_inst         = !ld;
    ls_op              = op;
    ls_sext            = sext;
    dest_reg           = dest;
    alu_result         = addr;
    result_2           = r2;
    result_from_mem_wb = rwb;
    B_fwd_from         = fwd;
    waited             = 0;
    @(negedge clock);
    while (stall && waited < WAIT_LIMIT) begin
      stall_seen = 1'b1;
      @(negedge clock);
      waited++;
    end
    if (stall) begin
      timeouts++;
      $display("Request at %h was never accepted, stall stuck high (%0t)", addr, $time);
    end
    @(posedge clock);
    #1;
    load_inst  = 1'b0;
    store_inst = 1'b0;
  endtask

  task automatic store_through(input lsu_pkg::ls_op_t op, input lsu_pkg::addr_t addr,
                               input lsu_pkg::word_t data, input lsu_pkg::fwd_t fwd);
    lsu_pkg::word_t other;
    other = ~data ^ 32'h1357_9bdf;   // Decoy on the unselected operand
    if (fwd == lsu_pkg::FWD_FROM_MEMWB_LATE) begin
      issue_request(1'b0, op, 1'b0, '0, addr, other, data, fwd);
    end else begin
      issue_request(1'b0, op, 1'b0, '0, addr, data, other, fwd);
    end
    store_ref(op, addr, data);
  endtask

  task automatic load_and_check(input lsu_pkg::ls_op_t op, input logic sext,
                                input lsu_pkg::addr_t addr, input lsu_pkg::reg_idx_t dest);
    lsu_pkg::word_t exp;
    int             waited;
    logic           seen;
    exp    = expect_load(ref_mem[addr[9:2]], op, sext, addr[1:0]);
    issue_request(1'b1, op, sext, dest, addr, '0, '0, lsu_pkg::FWD_NONE);
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < WAIT_LIMIT) begin
      @(negedge clock);
      seen = load_done;
      waited++;
    end
    if (seen) begin
      check_word($sformatf("load %s at %h sext %b", op.name(), addr, sext), load_data, exp);
      check_dest("load_dest", load_dest, dest);
    end else begin
      timeouts++;
      $display("Load at %h never returned load_done (%0t)", addr, $time);
    end
    @(posedge clock);
    #1;
  endtask

  task automatic idle_cycle_passes_result;
    alu_result = $random(seed);
    @(negedge clock);
    check_word("result on idle cycle", result, alu_result);
    check_bit("stall on idle cycle", stall, 1'b0);
    @(posedge clock);
    #1;
  endtask

  task automatic word_store_load;
    store_through(lsu_pkg::OP_LS_WORD, 32'h40, $random(seed), lsu_pkg::FWD_NONE);
    load_and_check(lsu_pkg::OP_LS_WORD, 1'b0, 32'h40, 5'd13);
  endtask

  task automatic byte_lane_stores;
    log_sel.delete();
    log_dat.delete();
    log_adr.delete();
    for (int i = 0; i < 4; i++) begin
      store_through(lsu_pkg::OP_LS_BYTE, 32'h80 + i, $random(seed), lsu_pkg::FWD_NONE);
    end
    load_and_check(lsu_pkg::OP_LS_WORD, 1'b0, 32'h80, 5'd2);  // Merged word
    if (log_sel.size() != 4) begin
      errors++;
      $display("FAIL %0t: %0d byte writes on the bus, expected 4", $time, log_sel.size());
    end else begin
      for (int i = 0; i < 4; i++) begin
        check_be($sformatf("wb_sel for byte %0d", i), log_sel[i],
                 lane_mask(lsu_pkg::OP_LS_BYTE, i));
        check_adr($sformatf("wb_adr for byte %0d", i), log_adr[i],
                  lsu_pkg::waddr_t'((32'h80 + i) >> 2));
      end
    end
  endtask

  task automatic narrow_loads;
    store_through(lsu_pkg::OP_LS_WORD, 32'h200, 32'h807f_f12a, lsu_pkg::FWD_NONE);
    store_through(lsu_pkg::OP_LS_WORD, 32'h204, 32'h7f80_2af1, lsu_pkg::FWD_NONE);
    for (int w = 0; w < 2; w++) begin
      for (int i = 0; i < 4; i++) begin
        for (int s = 0; s < 2; s++) begin
          load_and_check(lsu_pkg::OP_LS_BYTE, s == 1, 32'h200 + 4 * w + i, 5'(i + 4));
          if (i % 2 == 0) begin
            load_and_check(lsu_pkg::OP_LS_HALFWORD, s == 1, 32'h200 + 4 * w + i, 5'(i + 20));
          end
        end
      end
    end
  endtask

  task automatic store_forwarding;
    store_through(lsu_pkg::OP_LS_WORD, 32'h240, $random(seed), lsu_pkg::FWD_FROM_MEMWB_LATE);
    load_and_check(lsu_pkg::OP_LS_WORD, 1'b0, 32'h240, 5'd30);
    store_through(lsu_pkg::OP_LS_WORD, 32'h244, $random(seed), lsu_pkg::FWD_NONE);
    load_and_check(lsu_pkg::OP_LS_WORD, 1'b0, 32'h244, 5'd31);
  endtask

  task automatic burst_backpressure;
    lsu_pkg::word_t vals [8];
    log_sel.delete();
    log_dat.delete();
    log_adr.delete();
    stall_seen = 1'b0;
    for (int i = 0; i < 8; i++) begin
      vals[i] = $random(seed);
      store_through(lsu_pkg::OP_LS_WORD, 32'h300, vals[i], lsu_pkg::FWD_NONE);
    end
    check_bit("stall seen during store burst", stall_seen, 1'b1);
    load_and_check(lsu_pkg::OP_LS_WORD, 1'b0, 32'h300, 5'd21);  // Last value wins
    if (log_dat.size() != 8) begin
      errors++;
      $display("FAIL %0t: %0d burst writes on the bus, expected 8", $time, log_dat.size());
    end else begin
      for (int i = 0; i < 8; i++) begin
        check_word($sformatf("burst write %0d", i), log_dat[i], vals[i]);
        check_adr($sformatf("burst address %0d", i), log_adr[i],
                  lsu_pkg::waddr_t'(32'h300 >> 2));
      end
    end
  endtask

  initial begin
    clock              = 1'b0;
    arst_n             = 1'b0;
    load_inst          = 1'b0;
    store_inst         = 1'b0;
    ls_op              = lsu_pkg::OP_LS_WORD;
    ls_sext            = 1'b0;
    dest_reg           = '0;
    alu_result         = '0;
    result_2           = '0;
    result_from_mem_wb = '0;
    B_fwd_from         = lsu_pkg::FWD_NONE;
    seed               = 32'hbb78;
    checks             = 0;
    errors             = 0;
    timeouts           = 0;
    stall_seen         = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507);  // Same fill as the memory model
    end
    repeat (16) @(posedge clock);
    #1 arst_n = 1'b1;
    @(negedge clock);
    check_bit("stall after reset", stall, 1'b0);
    check_bit("load_done after reset", load_done, 1'b0);
    check_bit("wb_cyc after reset", wb_cyc, 1'b0);
    check_bit("wb_stb after reset", wb_stb, 1'b0);
    check_bit("wb_we after reset", wb_we, 1'b0);
    @(posedge clock);
    #1;
    idle_cycle_passes_result();
    word_store_load();
    byte_lane_stores();
    narrow_loads();
    store_forwarding();
    burst_backpressure();
    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sim/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
  input  logic            clock,
  input  logic            arst_n,
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  lsu_pkg::waddr_t adr,
  input  lsu_pkg::be_t    sel,
  input  lsu_pkg::word_t  dat_w,
  output lsu_pkg::word_t  dat_r,
  output logic            ack
);

  lsu_pkg::word_t mem [256];
  integer         seed;
  int             wait_cnt;
  int             delay;

  initial begin
    seed = 32'hbb78;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507);  // Every address bit shows up
    end
  end

  // Registered ack after 0 to 7 extra wait cycles
  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ack      <= 1'b0;
      dat_r    <= '0;
      wait_cnt <= 0;
      delay    <= 0;
    end else if (ack) begin
      ack      <= 1'b0;
      wait_cnt <= 0;
      delay    <= $unsigned($random(seed)) % 8;
    end else if (cyc && stb) begin
      if (wait_cnt >= delay) begin
        ack <= 1'b1;
        if (we) begin
          for (int l = 0; l < 4; l++) begin
            if (sel[3-l]) mem[adr[7:0]][31-8*l -: 8] <= dat_w[31-8*l -: 8];  // Lane l is byte l
          end
        end else begin
          dat_r <= mem[adr[7:0]];
        end
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end
  end

endmodule

//--- verilog.f
verilog/lsu_pkg.sv
verilog/ls_req_if.sv
verilog/mem_stage.sv
verilog/req_fifo.sv
verilog/wb_master.sv
verilog/lsu_top.sv
sim/wb_mem_model.sv
sim/tb_lsu.sv

//--- verilog/ls_req_if.sv
`timescale 1ns/1ps

interface ls_req_if;

  logic               valid;
  logic               ready;
  lsu_pkg::ls_entry_t entry;

  // Entry must stay stable while valid is high and ready is low
  modport producer (
    output valid,
    output entry,
    input  ready
  );

  modport consumer (
    input  valid,
    input  entry,
    output ready
  );

endinterface

//--- verilog/lsu_pkg.sv
package lsu_pkg;

  // Data and address widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [29:0] waddr_t;     // Byte address without bits 1..0
  typedef logic [3:0]  be_t;        // Bit 3 selects bits 31..24
  typedef logic [1:0]  byte_idx_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [1:0] {
    OP_LS_WORD,
    OP_LS_HALFWORD,
    OP_LS_BYTE
  } ls_op_t;

  typedef enum logic {
    FWD_NONE,
    FWD_FROM_MEMWB_LATE
  } fwd_t;

  // One slot of the request queue
  typedef struct packed {
    logic      we;          // Store when set, load otherwise
    waddr_t    waddr;
    word_t     wdata;       // Already placed in its byte lanes
    be_t       sel;
    ls_op_t    op;
    logic      sext;
    byte_idx_t byte_idx;    // Needed on the way back for load extraction
    reg_idx_t  dest;
  } ls_entry_t;

endpackage

//--- verilog/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              load_inst,
  input  logic              store_inst,
  input  lsu_pkg::ls_op_t   ls_op,
  input  logic              ls_sext,
  input  lsu_pkg::reg_idx_t dest_reg,
  input  lsu_pkg::addr_t    alu_result,
  input  lsu_pkg::word_t    result_2,
  input  lsu_pkg::word_t    result_from_mem_wb,
  input  lsu_pkg::fwd_t     B_fwd_from,
  output lsu_pkg::word_t    result,
  output logic              stall,
  output logic              load_done,
  output lsu_pkg::word_t    load_data,
  output lsu_pkg::reg_idx_t load_dest,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output lsu_pkg::waddr_t   wb_adr,
  output lsu_pkg::be_t      wb_sel,
  output lsu_pkg::word_t    wb_dat_o,
  input  lsu_pkg::word_t    wb_dat_i,
  input  logic              wb_ack
);

  ls_req_if req_in ();    // mem_stage to queue
  ls_req_if req_out ();   // Queue to bus master

  mem_stage u_mem_stage (
    .clock              (clock),
    .arst_n             (arst_n),
    .load_inst          (load_inst),
    .store_inst         (store_inst),
    .ls_op              (ls_op),
    .ls_sext            (ls_sext),
    .dest_reg           (dest_reg),
    .alu_result         (alu_result),
    .result_2           (result_2),
    .result_from_mem_wb (result_from_mem_wb),
    .B_fwd_from         (B_fwd_from),
    .load_done          (load_done),
    .result             (result),
    .stall              (stall),
    .req                (req_in.producer)
  );

  req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_req_fifo (
    .clock   (clock),
    .arst_n  (arst_n),
    .in_req  (req_in.consumer),
    .out_req (req_out.producer)
  );

  wb_master u_wb_master (
    .clock     (clock),
    .arst_n    (arst_n),
    .req       (req_out.consumer),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_sel    (wb_sel),
    .wb_dat_o  (wb_dat_o),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .load_done (load_done),
    .load_data (load_data),
    .load_dest (load_dest)
  );

endmodule

//--- verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              load_inst,
  input  logic              store_inst,
  input  lsu_pkg::ls_op_t   ls_op,
  input  logic              ls_sext,
  input  lsu_pkg::reg_idx_t dest_reg,
  input  lsu_pkg::addr_t    alu_result,
  input  lsu_pkg::word_t    result_2,
  input  lsu_pkg::word_t    result_from_mem_wb,
  input  lsu_pkg::fwd_t     B_fwd_from,
  input  logic              load_done,
  output lsu_pkg::word_t    result,
  output logic              stall,
  ls_req_if.producer        req
);

  lsu_pkg::word_t     word_st;
  lsu_pkg::word_t     word_lanes;
  lsu_pkg::be_t       lane_sel;
  lsu_pkg::byte_idx_t byte_idx;
  lsu_pkg::ls_entry_t entry;
  logic [4:0]         byte_msb;
  logic [4:0]         half_msb;
  logic               load_pending;
  logic               hold_load;
  logic               accept_load;

  assign word_st  = (B_fwd_from == lsu_pkg::FWD_FROM_MEMWB_LATE) ? result_from_mem_wb : result_2;
  assign byte_idx = alu_result[1:0];
  assign byte_msb = 5'd31 - {byte_idx, 3'b000};
  assign half_msb = 5'd31 - {byte_idx[1], 4'b0000};  // Halfwords sit on even bytes

  assign result = alu_result;

  // Big-endian lane placement, byte index 0 is the top byte
  always_comb begin
    word_lanes = word_st;
    lane_sel   = 4'b1111;
    case (ls_op)
      lsu_pkg::OP_LS_BYTE: begin
        word_lanes                = '0;
        word_lanes[byte_msb -: 8] = word_st[7:0];
        lane_sel                  = 4'b1000 >> byte_idx;
      end
      lsu_pkg::OP_LS_HALFWORD: begin
        word_lanes                 = '0;
        word_lanes[half_msb -: 16] = word_st[15:0];
        lane_sel                   = byte_idx[1] ? 4'b0011 : 4'b1100;
      end
      default: ;
    endcase
  end

  always_comb begin
    entry.we       = store_inst;
    entry.waddr    = alu_result[31:2];
    entry.wdata    = word_lanes;
    entry.sel      = lane_sel;
    entry.op       = ls_op;
    entry.sext     = ls_sext;
    entry.byte_idx = byte_idx;
    entry.dest     = dest_reg;
  end

  // Pipeline may move again in the cycle load_done pulses
  assign hold_load   = load_pending & ~load_done;
  assign req.valid   = (load_inst | store_inst) & ~hold_load;
  assign req.entry   = entry;
  assign stall       = hold_load | ~req.ready;
  assign accept_load = req.valid & req.ready & load_inst;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      load_pending <= 1'b0;
    end else if (accept_load) begin
      load_pending <= 1'b1;
    end else if (load_done) begin
      load_pending <= 1'b0;
    end
  end

  // No misaligned access ever reaches the queue
  a_aligned: assert property (@(posedge clock) disable iff (!arst_n)
    req.valid |-> ((ls_op == lsu_pkg::OP_LS_WORD)     ? (alu_result[1:0] == 2'b00) :
                   (ls_op == lsu_pkg::OP_LS_HALFWORD) ? !alu_result[0] : 1'b1));

endmodule

//--- verilog/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       clock,
  input  logic       arst_n,
  ls_req_if.consumer in_req,
  ls_req_if.producer out_req
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  lsu_pkg::ls_entry_t slots [FIFO_DEPTH];
  logic [PTR_W:0]     wr_ptr;    // Top bit is the wrap flag
  logic [PTR_W:0]     rd_ptr;
  logic [PTR_W:0]     fill;
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  // Same slot, different lap means full
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);
  assign fill  = wr_ptr - rd_ptr;

  assign in_req.ready  = ~full;
  assign out_req.valid = ~empty;
  assign out_req.entry = slots[rd_ptr[PTR_W-1:0]];

  assign push = in_req.valid & in_req.ready;
  assign pop  = out_req.valid & out_req.ready;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      slots[wr_ptr[PTR_W-1:0]] <= in_req.entry;
    end
  end

  // Occupancy stays in range, so no push on full and no pop on empty slipped through
  a_fill_range: assert property (@(posedge clock) disable iff (!arst_n)
    fill <= FIFO_DEPTH);

  // A stalled producer keeps its request
  a_in_hold: assert property (@(posedge clock) disable iff (!arst_n)
    in_req.valid && !in_req.ready |=> in_req.valid && $stable(in_req.entry));

endmodule

//--- verilog/wb_master.sv
`timescale 1ns/1ps

module wb_master (
  input  logic              clock,
  input  logic              arst_n,
  ls_req_if.consumer        req,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output lsu_pkg::waddr_t   wb_adr,
  output lsu_pkg::be_t      wb_sel,
  output lsu_pkg::word_t    wb_dat_o,
  input  lsu_pkg::word_t    wb_dat_i,
  input  logic              wb_ack,
  output logic              load_done,
  output lsu_pkg::word_t    load_data,
  output lsu_pkg::reg_idx_t load_dest
);

  typedef enum logic [1:0] {
    WB_IDLE,
    WB_ACCESS,
    WB_RESP
  } wb_state_t;

  wb_state_t          state;
  wb_state_t          state_nxt;
  lsu_pkg::ls_entry_t cur;         // Request being served
  lsu_pkg::word_t     ext_data;
  logic [4:0]         byte_msb;
  logic [4:0]         half_msb;
  logic               take;

  // Head can be taken in the gap cycle after an ack too
  assign req.ready = (state != WB_ACCESS);
  assign take      = req.valid & req.ready;

  always_comb begin
    state_nxt = state;
    case (state)
      WB_IDLE:   if (req.valid) state_nxt = WB_ACCESS;
      WB_ACCESS: if (wb_ack)    state_nxt = WB_RESP;
      WB_RESP:   state_nxt = req.valid ? WB_ACCESS : WB_IDLE;
      default:   state_nxt = WB_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= WB_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clock) begin
    if (take) cur <= req.entry;
    if (state == WB_ACCESS && wb_ack && !cur.we) begin
      load_data <= ext_data;
    end
  end

  assign byte_msb = 5'd31 - {cur.byte_idx, 3'b000};
  assign half_msb = 5'd31 - {cur.byte_idx[1], 4'b0000};

  // Pick the addressed lanes out of the returned word and extend
  always_comb begin
    ext_data = wb_dat_i;
    case (cur.op)
      lsu_pkg::OP_LS_BYTE: begin
        ext_data[7:0]  = wb_dat_i[byte_msb -: 8];
        ext_data[31:8] = cur.sext ? {24{ext_data[7]}} : 24'h0;
      end
      lsu_pkg::OP_LS_HALFWORD: begin
        ext_data[15:0]  = wb_dat_i[half_msb -: 16];
        ext_data[31:16] = cur.sext ? {16{ext_data[15]}} : 16'h0;
      end
      default: ;
    endcase
  end

  assign wb_cyc   = (state == WB_ACCESS);
  assign wb_stb   = (state == WB_ACCESS);
  assign wb_we    = wb_cyc & cur.we;
  assign wb_adr   = cur.waddr;
  assign wb_sel   = cur.sel;
  assign wb_dat_o = cur.wdata;

  assign load_done = (state == WB_RESP) & ~cur.we;  // One cycle, right after the ack edge
  assign load_dest = cur.dest;

  // Classic cycle holds strobe and payload until the slave acks
  a_stb_hold: assert property (@(posedge clock) disable iff (!arst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) &&
                          $stable(wb_sel) && $stable(wb_dat_o));

endmodule
